/* isaPkg.sv */
package isaPkg;

	// Widths.
	localparam int WordWidth = 32;
	localparam int IAddrWidth = 8;
	localparam int DAddrWidth = 8;
	localparam int RegIdxWidth = 5;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [IAddrWidth-1:0] iaddr_t;
	typedef logic [DAddrWidth-1:0] daddr_t;
	typedef logic [RegIdxWidth-1:0] regIdx_t;

	// ------------------------------------------------------------
	// Opcodes.
	localparam logic [5:0] OpRType = 6'b000000;
	localparam logic [5:0] OpAddi = 6'b001000;
	localparam logic [5:0] OpSubi = 6'b001001;
	localparam logic [5:0] OpAndi = 6'b001100;
	localparam logic [5:0] OpOri = 6'b001101;
	localparam logic [5:0] OpLw = 6'b100011;
	localparam logic [5:0] OpSw = 6'b101011;
	localparam logic [5:0] OpJpc = 6'b000010;
	localparam logic [5:0] OpBrfl = 6'b000100;
	localparam logic [5:0] OpCall = 6'b000011;
	localparam logic [5:0] OpRet = 6'b000001;
	localparam logic [5:0] OpHalt = 6'b111111;

	// Funct codes for register-type instructions.
	localparam logic [5:0] FnAdd = 6'b100000;
	localparam logic [5:0] FnSub = 6'b100010;
	localparam logic [5:0] FnAnd = 6'b100100;
	localparam logic [5:0] FnOr = 6'b100101;
	localparam logic [5:0] FnSlt = 6'b101010;
	localparam logic [5:0] FnMul = 6'b011000;

	// ------------------------------------------------------------
	// Instruction field positions.
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsMsb = 25;
	localparam int RsLsb = 21;
	localparam int RtMsb = 20;
	localparam int RtLsb = 16;
	localparam int RdMsb = 15;
	localparam int RdLsb = 11;
	localparam int FunctMsb = 5;
	localparam int FunctLsb = 0;
	localparam int ImmMsb = 15;
	localparam int ImmLsb = 0;
	localparam int TargetMsb = 7;
	localparam int TargetLsb = 0;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

	// ALU operation; AluFunct defers to the funct field.
	typedef enum logic [2:0] {
		AluAdd = 3'd0,
		AluSub = 3'd1,
		AluAnd = 3'd2,
		AluOr = 3'd3,
		AluSlt = 3'd4,
		AluMul = 3'd5,
		AluFunct = 3'd6
	} aluOp_t;

	// Next program counter source.
	typedef enum logic [1:0] {
		PcNext = 2'd0,
		PcBranch = 2'd1,
		PcJump = 2'd2,
		PcReturn = 2'd3
	} pcSrc_t;

	// Second ALU operand.
	typedef enum logic {
		OpbReg = 1'b0,
		OpbImm = 1'b1
	} opbSel_t;

	// Five stages per instruction.
	typedef enum logic [2:0] {
		StFetch = 3'd0,
		StDecode = 3'd1,
		StExecute = 3'd2,
		StMemory = 3'd3,
		StWriteback = 3'd4
	} stage_t;

	localparam int StackDepth = 8;

endpackage

/* aluUnit.sv */
module aluUnit (
	input ctrlPkg::aluOp_t op,
	input logic [5:0] funct,
	input isaPkg::word_t a,
	input isaPkg::word_t b,
	output isaPkg::word_t result,
	output logic zero
);

	ctrlPkg::aluOp_t effOp;

	// Register-type instructions take the operation from funct.
	always_comb
	begin
		effOp = op;
		if (op == ctrlPkg::AluFunct)
		begin
			case (funct)
				isaPkg::FnSub: effOp = ctrlPkg::AluSub;
				isaPkg::FnAnd: effOp = ctrlPkg::AluAnd;
				isaPkg::FnOr: effOp = ctrlPkg::AluOr;
				isaPkg::FnSlt: effOp = ctrlPkg::AluSlt;
				isaPkg::FnMul: effOp = ctrlPkg::AluMul;
				default: effOp = ctrlPkg::AluAdd;
			endcase
		end
	end

	always_comb
	begin
		case (effOp)
			ctrlPkg::AluSub:
				result = a - b;
			ctrlPkg::AluAnd:
				result = a & b;
			ctrlPkg::AluOr:
				result = a | b;
			ctrlPkg::AluSlt:
				result = ($signed(a) < $signed(b)) ? isaPkg::word_t'(1) : '0;
			ctrlPkg::AluMul:
				// Low half of the product.
				result = a * b;
			default:
				result = a + b;
		endcase
	end

	assign zero = result == '0;

endmodule

/* registerFile.sv */
module registerFile (
	input logic clk,
	input logic reset,
	input isaPkg::regIdx_t readIdxA,
	input isaPkg::regIdx_t readIdxB,
	output isaPkg::word_t readDataA,
	output isaPkg::word_t readDataB,
	input logic writeEn,
	input isaPkg::regIdx_t writeIdx,
	input isaPkg::word_t writeData
);

	localparam int NumRegs = 2 ** isaPkg::RegIdxWidth;

	isaPkg::word_t regs [NumRegs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end
		else if (writeEn && writeIdx != '0)
			regs[writeIdx] <= writeData;
	end

	// Register 0 always reads zero.
	assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
	assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

endmodule

/* returnStack.sv */
module returnStack #(
	parameter int Depth = ctrlPkg::StackDepth
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input isaPkg::iaddr_t pushAddr,
	output isaPkg::iaddr_t topAddr
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

	isaPkg::iaddr_t entries [Depth];
	logic [PtrWidth-1:0] ptr;
	logic [PtrWidth-1:0] topPtr;
	logic [PtrWidth:0] count;

	// Pointer marks the next free slot and wraps around.
	assign topPtr = (ptr == '0) ? PtrWidth'(Depth - 1) : ptr - 1'b1;
	assign topAddr = (count == '0) ? '0 : entries[topPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
			count <= '0;
		end
		else if (push)
		begin
			ptr <= (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
			if (count != (PtrWidth + 1)'(Depth))
				count <= count + 1'b1;
		end
		else if (pop && count != '0)
		begin
			ptr <= topPtr;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			entries[ptr] <= pushAddr;
	end

endmodule

/* controlUnit.sv */
module controlUnit (
	input logic clk,
	input logic reset,
	input logic [5:0] opcode,
	input logic [5:0] funct,
	input logic aluZero,
	output ctrlPkg::stage_t stage,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::opbSel_t opbSel,
	output logic regDst,
	output logic memToReg,
	output logic memRead,
	output logic memWrite,
	output logic regWrite,
	output logic push,
	output logic pop,
	output logic pcWrite,
	output ctrlPkg::pcSrc_t pcSrc,
	output logic halted
);

	logic isLoad;
	logic isStore;
	logic writesReg;
	logic pushesRet;
	logic popsRet;
	logic isHalt;
	logic functValid;
	logic atMemory;
	logic atWriteback;
	logic active;

	// ------------------------------------------------------------
	// Stage counter and halt flag.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage <= ctrlPkg::StFetch;
			halted <= 1'b0;
		end
		else
		begin
			if (stage == ctrlPkg::StWriteback)
				stage <= ctrlPkg::StFetch;
			else
				stage <= ctrlPkg::stage_t'(stage + 3'd1);
			if (atWriteback && isHalt)
				halted <= 1'b1;
		end
	end

	// Unknown funct codes behave as a no-op.
	assign functValid = funct inside {isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd,
		isaPkg::FnOr, isaPkg::FnSlt, isaPkg::FnMul};

	// ------------------------------------------------------------
	// Opcode decoder.
	always_comb
	begin
		aluOp = ctrlPkg::AluAdd;
		opbSel = ctrlPkg::OpbReg;
		pcSrc = ctrlPkg::PcNext;
		regDst = 1'b0;
		memToReg = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		writesReg = 1'b0;
		pushesRet = 1'b0;
		popsRet = 1'b0;
		isHalt = 1'b0;
		case (opcode)
			isaPkg::OpRType:
			begin
				aluOp = ctrlPkg::AluFunct;
				regDst = 1'b1;
				writesReg = functValid;
			end
			isaPkg::OpAddi, isaPkg::OpSubi, isaPkg::OpAndi, isaPkg::OpOri:
			begin
				opbSel = ctrlPkg::OpbImm;
				writesReg = 1'b1;
				case (opcode)
					isaPkg::OpSubi: aluOp = ctrlPkg::AluSub;
					isaPkg::OpAndi: aluOp = ctrlPkg::AluAnd;
					isaPkg::OpOri: aluOp = ctrlPkg::AluOr;
					default: aluOp = ctrlPkg::AluAdd;
				endcase
			end
			isaPkg::OpLw:
			begin
				opbSel = ctrlPkg::OpbImm;
				memToReg = 1'b1;
				isLoad = 1'b1;
				writesReg = 1'b1;
			end
			isaPkg::OpSw:
			begin
				opbSel = ctrlPkg::OpbImm;
				isStore = 1'b1;
			end
			isaPkg::OpJpc:
				pcSrc = ctrlPkg::PcJump;
			isaPkg::OpBrfl:
			begin
				// Equal operands give a zero difference.
				aluOp = ctrlPkg::AluSub;
				pcSrc = aluZero ? ctrlPkg::PcBranch : ctrlPkg::PcNext;
			end
			isaPkg::OpCall:
			begin
				pushesRet = 1'b1;
				pcSrc = ctrlPkg::PcJump;
			end
			isaPkg::OpRet:
			begin
				popsRet = 1'b1;
				pcSrc = ctrlPkg::PcReturn;
			end
			isaPkg::OpHalt:
				isHalt = 1'b1;
			default:
				pcSrc = ctrlPkg::PcNext;
		endcase
	end

	// ------------------------------------------------------------
	// Stage-gated strobes.
	assign atMemory = stage == ctrlPkg::StMemory;
	assign atWriteback = stage == ctrlPkg::StWriteback;
	assign active = !halted;

	assign memRead = isLoad && atMemory && active;
	assign memWrite = isStore && atMemory && active;
	assign regWrite = writesReg && atWriteback && active;
	assign push = pushesRet && atWriteback && active;
	assign pop = popsRet && atWriteback && active;
	assign pcWrite = !isHalt && atWriteback && active;

endmodule

/* cpuCore.sv */
module cpuCore (
	input logic clk,
	input logic reset,
	output isaPkg::iaddr_t instrAddr,
	input isaPkg::word_t instrData,
	output isaPkg::daddr_t memAddr,
	output isaPkg::word_t memWriteData,
	input isaPkg::word_t memReadData,
	output logic memRead,
	output logic memWrite,
	output logic halted
);

	isaPkg::iaddr_t pc;
	isaPkg::iaddr_t pcPlusOne;
	isaPkg::iaddr_t branchTarget;
	isaPkg::iaddr_t jumpTarget;
	isaPkg::iaddr_t nextPc;
	isaPkg::iaddr_t topAddr;
	isaPkg::word_t instr;
	isaPkg::word_t regA;
	isaPkg::word_t regB;
	isaPkg::word_t readDataA;
	isaPkg::word_t readDataB;
	isaPkg::word_t immExt;
	isaPkg::word_t opB;
	isaPkg::word_t aluOut;
	isaPkg::word_t aluResult;
	isaPkg::word_t memData;
	isaPkg::word_t writeData;
	isaPkg::regIdx_t rsIdx;
	isaPkg::regIdx_t rtIdx;
	isaPkg::regIdx_t rdIdx;
	isaPkg::regIdx_t writeIdx;
	logic [5:0] opcode;
	logic [5:0] funct;
	ctrlPkg::stage_t stage;
	ctrlPkg::aluOp_t aluOp;
	ctrlPkg::opbSel_t opbSel;
	ctrlPkg::pcSrc_t pcSrc;
	logic regDst;
	logic memToReg;
	logic regWrite;
	logic push;
	logic pop;
	logic pcWrite;
	logic aluZero;

	// ------------------------------------------------------------
	// Instruction fields.
	assign opcode = instr[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
	assign rsIdx = instr[isaPkg::RsMsb:isaPkg::RsLsb];
	assign rtIdx = instr[isaPkg::RtMsb:isaPkg::RtLsb];
	assign rdIdx = instr[isaPkg::RdMsb:isaPkg::RdLsb];
	assign funct = instr[isaPkg::FunctMsb:isaPkg::FunctLsb];
	assign immExt = {{(isaPkg::WordWidth - isaPkg::ImmMsb - 1){instr[isaPkg::ImmMsb]}},
		instr[isaPkg::ImmMsb:isaPkg::ImmLsb]};
	assign jumpTarget = instr[isaPkg::TargetMsb:isaPkg::TargetLsb];

	// ------------------------------------------------------------
	// Program counter.
	assign pcPlusOne = pc + 1'b1;
	assign branchTarget = pcPlusOne + immExt[isaPkg::IAddrWidth-1:0];

	always_comb
	begin
		case (pcSrc)
			ctrlPkg::PcBranch: nextPc = branchTarget;
			ctrlPkg::PcJump: nextPc = jumpTarget;
			ctrlPkg::PcReturn: nextPc = topAddr;
			default: nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else if (pcWrite)
			pc <= nextPc;
	end

	assign instrAddr = pc;

	// Datapath registers, each loaded in its own stage.
	always_ff @(posedge clk)
	begin
		case (stage)
			ctrlPkg::StFetch:
				instr <= instrData;
			ctrlPkg::StDecode:
			begin
				regA <= readDataA;
				regB <= readDataB;
			end
			ctrlPkg::StExecute:
				aluResult <= aluOut;
			ctrlPkg::StMemory:
				memData <= memReadData;
			default:
				instr <= instr;
		endcase
	end

	assign opB = (opbSel == ctrlPkg::OpbImm) ? immExt : regB;
	assign writeIdx = regDst ? rdIdx : rtIdx;
	assign writeData = memToReg ? memData : aluResult;

	// Word-addressed data memory.
	assign memAddr = aluResult[isaPkg::DAddrWidth-1:0];
	assign memWriteData = regB;

	// ------------------------------------------------------------
	controlUnit ctrl (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.aluZero(aluZero),
		.stage(stage),
		.aluOp(aluOp),
		.opbSel(opbSel),
		.regDst(regDst),
		.memToReg(memToReg),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.push(push),
		.pop(pop),
		.pcWrite(pcWrite),
		.pcSrc(pcSrc),
		.halted(halted)
	);

	aluUnit alu (
		.op(aluOp),
		.funct(funct),
		.a(regA),
		.b(opB),
		.result(aluOut),
		.zero(aluZero)
	);

	registerFile regs (
		.clk(clk),
		.reset(reset),
		.readIdxA(rsIdx),
		.readIdxB(rtIdx),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEn(regWrite),
		.writeIdx(writeIdx),
		.writeData(writeData)
	);

	returnStack stack (
		.clk(clk),
		.reset(reset),
		.push(push),
		.pop(pop),
		.pushAddr(pcPlusOne),
		.topAddr(topAddr)
	);

endmodule

/* cpuTb_chk.sv */
module cpuTb_chk (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic regWrite,
	input logic push,
	input logic pop,
	input logic pcWrite,
	input logic halted,
	input isaPkg::iaddr_t instrAddr
);

	int unsigned failCount = 0;
	logic anyStrobe;

	assign anyStrobe = memRead || memWrite || regWrite || push || pop || pcWrite;

	memExclusive: assert property (@(posedge clk) disable iff (reset)
		!(memRead && memWrite))
	else
	begin
		$error("memRead and memWrite high in the same cycle");
		failCount++;
	end

	pcWriteSingle: assert property (@(posedge clk) disable iff (reset)
		pcWrite |=> !pcWrite)
	else
	begin
		$error("pcWrite high in consecutive cycles");
		failCount++;
	end

	quietHalt: assert property (@(posedge clk) disable iff (reset)
		halted |-> !anyStrobe)
	else
	begin
		$error("strobe issued while halted");
		failCount++;
	end

	fetchStable: assert property (@(posedge clk) disable iff (reset)
		!$past(pcWrite) |-> $stable(instrAddr))
	else
	begin
		$error("instrAddr changed without pcWrite");
		failCount++;
	end

endmodule

/* cpuTb.sv */
module cpuTb;

	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 5;
	localparam int PostHaltCycles = 20;
	localparam int MarginCycles = 50;
	localparam int MaxSteps = 2000;
	localparam int unsigned Seed = 32'h7e624470;
	localparam int MemWords = 2 ** isaPkg::IAddrWidth;

	logic clk = 1'b0;
	logic reset;
	isaPkg::iaddr_t instrAddr;
	isaPkg::word_t instrData;
	isaPkg::daddr_t memAddr;
	isaPkg::word_t memWriteData;
	isaPkg::word_t memReadData;
	logic memRead;
	logic memWrite;
	logic halted;

	isaPkg::word_t progMem [MemWords];
	isaPkg::word_t dataMem [MemWords];
	isaPkg::word_t initData [MemWords];
	isaPkg::daddr_t expAddr [$];
	isaPkg::word_t expData [$];
	isaPkg::iaddr_t finalPc;
	int instrCount;
	int progLen;
	logic [15:0] storeSlot;
	int storeIdx = 0;
	int mismatchCount = 0;
	int otherCount = 0;
	time watchLimit = 0;

	always #(ClkPeriod / 2) clk = ~clk;

	cpuCore dut_i (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.memRead(memRead),
		.memWrite(memWrite),
		.halted(halted)
	);

	bind cpuCore cpuTb_chk chk_i (
		.clk(clk),
		.reset(reset),
		.memRead(memRead),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.push(push),
		.pop(pop),
		.pcWrite(pcWrite),
		.halted(halted),
		.instrAddr(instrAddr)
	);

	// Both memories answer in the same cycle.
	// Data memory drives its output only during a read.
	assign instrData = progMem[instrAddr];
	assign memReadData = memRead ? dataMem[memAddr] : 'x;

	always @(posedge clk)
	begin
		if (!reset && memWrite)
			dataMem[memAddr] <= memWriteData;
	end

	// ------------------------------------------------------------
	// Compare tasks.
	task automatic checkWord(input string name, input isaPkg::word_t got,
		input isaPkg::word_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	task automatic checkDataAddr(input string name, input isaPkg::daddr_t got,
		input isaPkg::daddr_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	task automatic checkInstrAddr(input string name, input isaPkg::iaddr_t got,
		input isaPkg::iaddr_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("mismatch at %0t: %s got %b, expected %b", $time, name, got, want);
			mismatchCount++;
		end
	endtask

	// ------------------------------------------------------------
	// Instruction encoders.
	function automatic isaPkg::word_t encR(logic [5:0] fn, isaPkg::regIdx_t rd,
		isaPkg::regIdx_t rs, isaPkg::regIdx_t rt);
		return {isaPkg::OpRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isaPkg::word_t encI(logic [5:0] op, isaPkg::regIdx_t rt,
		isaPkg::regIdx_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::word_t encJ(logic [5:0] op, isaPkg::iaddr_t target);
		return {op, 18'd0, target};
	endfunction

	task automatic put(input isaPkg::word_t w);
		progMem[progLen] = w;
		progLen++;
	endtask

	// Store to the next free slot above the base in r10.
	task automatic putStore(input isaPkg::regIdx_t rt);
		put(encI(isaPkg::OpSw, rt, 5'd10, storeSlot));
		storeSlot++;
	endtask

	task automatic buildProgram();
		logic [5:0] fnList [6];
		logic [5:0] opList [4];
		fnList = '{isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnOr,
			isaPkg::FnSlt, isaPkg::FnMul};
		opList = '{isaPkg::OpAddi, isaPkg::OpSubi, isaPkg::OpAndi, isaPkg::OpOri};
		storeSlot = 16'd0;
		progLen = 0;
		put(encI(isaPkg::OpLw, 5'd3, 5'd0, 16'h0010));
		put(encI(isaPkg::OpLw, 5'd4, 5'd0, 16'h0011));
		put(encI(isaPkg::OpAddi, 5'd1, 5'd0, 16'($urandom)));
		// Store base 0x80 in r10.
		put(encI(isaPkg::OpOri, 5'd10, 5'd0, 16'h0080));
		for (int s = 0; s < 2; s++)
		begin
			foreach (fnList[i])
			begin
				put(encR(fnList[i], 5'd5, (s == 0) ? 5'd3 : 5'd1, 5'd4));
				putStore(5'd5);
			end
		end
		foreach (opList[i])
		begin
			put(encI(opList[i], 5'd6, 5'd3, 16'($urandom)));
			putStore(5'd6);
		end
		for (int i = 0; i < 3; i++)
		begin
			put(encI(isaPkg::OpLw, 5'd7, 5'd0, 16'(16'h0012 + i)));
			putStore(5'd7);
		end
		// Taken beq skips one store, the untaken one skips none.
		put(encI(isaPkg::OpBrfl, 5'd3, 5'd3, 16'd1));
		putStore(5'd1);
		putStore(5'd3);
		put(encI(isaPkg::OpBrfl, 5'd3, 5'd0, 16'd1));
		putStore(5'd4);
		put(encJ(isaPkg::OpJpc, isaPkg::iaddr_t'(progLen + 3)));
		putStore(5'd1);
		putStore(5'd3);
		putStore(5'd4);
		put(encJ(isaPkg::OpCall, 8'h60));
		putStore(5'd11);
		put(encJ(isaPkg::OpHalt, 8'h00));
		// Three nested subroutines.
		progLen = 'h60;
		put(encI(isaPkg::OpAddi, 5'd11, 5'd11, 16'd1));
		put(encJ(isaPkg::OpCall, 8'h68));
		putStore(5'd11);
		put(encJ(isaPkg::OpRet, 8'h00));
		progLen = 'h68;
		put(encI(isaPkg::OpAddi, 5'd11, 5'd11, 16'd2));
		put(encJ(isaPkg::OpCall, 8'h70));
		put(encI(isaPkg::OpSubi, 5'd11, 5'd11, 16'h0010));
		putStore(5'd11);
		put(encJ(isaPkg::OpRet, 8'h00));
		progLen = 'h70;
		put(encI(isaPkg::OpAddi, 5'd11, 5'd11, 16'd4));
		putStore(5'd11);
		put(encJ(isaPkg::OpRet, 8'h00));
	endtask

	// ------------------------------------------------------------
	// Instruction-set model.
	function automatic void refRun(output isaPkg::daddr_t addrs [$],
		output isaPkg::word_t datas [$], output isaPkg::iaddr_t endPc, output int count);
		isaPkg::word_t r [32];
		isaPkg::word_t mem [MemWords];
		isaPkg::iaddr_t stackMem [ctrlPkg::StackDepth];
		isaPkg::iaddr_t pc;
		isaPkg::iaddr_t nextPc;
		isaPkg::word_t ins;
		isaPkg::word_t a;
		isaPkg::word_t b;
		isaPkg::word_t imm;
		isaPkg::daddr_t ea;
		int sp;
		int depth;
		logic done;
		addrs = {};
		datas = {};
		foreach (r[i])
			r[i] = '0;
		mem = initData;
		pc = '0;
		sp = 0;
		depth = 0;
		count = 0;
		done = 1'b0;
		while (!done && count < MaxSteps)
		begin
			ins = progMem[pc];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea = isaPkg::daddr_t'(a + imm);
			nextPc = isaPkg::iaddr_t'(pc + 1);
			count++;
			case (ins[31:26])
				isaPkg::OpRType:
					case (ins[5:0])
						isaPkg::FnAdd: r[ins[15:11]] = a + b;
						isaPkg::FnSub: r[ins[15:11]] = a - b;
						isaPkg::FnAnd: r[ins[15:11]] = a & b;
						isaPkg::FnOr: r[ins[15:11]] = a | b;
						isaPkg::FnSlt: r[ins[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
						isaPkg::FnMul: r[ins[15:11]] = a * b;
						default: r[0] = '0;
					endcase
				isaPkg::OpAddi: r[ins[20:16]] = a + imm;
				isaPkg::OpSubi: r[ins[20:16]] = a - imm;
				isaPkg::OpAndi: r[ins[20:16]] = a & imm;
				isaPkg::OpOri: r[ins[20:16]] = a | imm;
				isaPkg::OpLw: r[ins[20:16]] = mem[ea];
				isaPkg::OpSw:
				begin
					mem[ea] = b;
					addrs.push_back(ea);
					datas.push_back(b);
				end
				isaPkg::OpJpc: nextPc = ins[7:0];
				isaPkg::OpBrfl:
					if (a == b)
						nextPc = isaPkg::iaddr_t'(pc + 1 + ins[7:0]);
				isaPkg::OpCall:
				begin
					stackMem[sp] = isaPkg::iaddr_t'(pc + 1);
					sp = (sp + 1) % ctrlPkg::StackDepth;
					if (depth < ctrlPkg::StackDepth)
						depth++;
					nextPc = ins[7:0];
				end
				isaPkg::OpRet:
				begin
					// Empty stack returns to address 0.
					nextPc = '0;
					if (depth > 0)
					begin
						sp = (sp + ctrlPkg::StackDepth - 1) % ctrlPkg::StackDepth;
						nextPc = stackMem[sp];
						depth--;
					end
				end
				isaPkg::OpHalt: done = 1'b1;
				default: r[0] = '0;
			endcase
			r[0] = '0;
			if (!done)
				pc = nextPc;
		end
		endPc = pc;
	endfunction

	// ------------------------------------------------------------
	// Store comparison against the model.
	always @(negedge clk)
	begin
		if (!reset && memWrite)
		begin
			if (storeIdx >= expAddr.size())
			begin
				$display("unexpected store at %0t to address %h, none was predicted",
					$time, memAddr);
				otherCount++;
			end
			else
			begin
				checkDataAddr("memAddr", memAddr, expAddr[storeIdx]);
				checkWord("memWriteData", memWriteData, expData[storeIdx]);
			end
			storeIdx++;
		end
	end

	initial
	begin
		wait (watchLimit != 0);
		#(watchLimit);
		$display("timeout at %0t: core did not halt in time", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		void'($urandom(Seed));
		for (int i = 0; i < MemWords; i++)
		begin
			// Stray fetches halt.
			progMem[i] = {isaPkg::OpHalt, 18'd0, 8'(i)};
			dataMem[i] = $urandom;
		end
		initData = dataMem;
		buildProgram();
		refRun(expAddr, expData, finalPc, instrCount);
		watchLimit = time'((ResetCycles + instrCount * 5 + PostHaltCycles + MarginCycles)
			* ClkPeriod);

		repeat (ResetCycles) @(negedge clk);
		checkBit("memRead", memRead, 1'b0);
		checkBit("memWrite", memWrite, 1'b0);
		checkBit("halted", halted, 1'b0);
		checkInstrAddr("instrAddr", instrAddr, '0);
		reset = 1'b0;

		wait (halted === 1'b1);
		repeat (PostHaltCycles) @(negedge clk);
		checkBit("halted", halted, 1'b1);
		checkInstrAddr("instrAddr", instrAddr, finalPc);
		if (storeIdx < expAddr.size())
		begin
			$display("only %0d of %0d predicted stores appeared", storeIdx, expAddr.size());
			otherCount++;
		end

		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
			mismatchCount, otherCount, dut_i.chk_i.failCount);
		if (mismatchCount == 0 && otherCount == 0 && dut_i.chk_i.failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sources.f */
isaPkg.sv
ctrlPkg.sv
aluUnit.sv
registerFile.sv
returnStack.sv
controlUnit.sv
cpuCore.sv
cpuTb_chk.sv
cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpuTb
FLAGS ?= --assert -Wno-fatal
SIMARGS ?= +verilator+error+limit+1000
OBJDIR := obj_dir

.PHONY: sim clean

# Pass only if the simulation prints the pass line.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f sources.f
	out=$$(./$(OBJDIR)/V$(TOP) $(SIMARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
